/* hw/cpuControlPkg.sv */
`default_nettype none

package cpuControlPkg;

	localparam int instrWidth = 16;
	localparam int groupWidth = 2;
	localparam int opcodeWidth = 4;
	localparam int argAWidth = 2;
	localparam int argBWidth = 4;
	localparam int conditionWidth = 4;
	localparam int flagsWidth = 3; // Negative, carry, zero.

	// Field positions in the instruction word.
	localparam int groupLsb = 14;
	localparam int opcodeLsb = 10;
	localparam int argALsb = 8;
	localparam int argBLsb = 4;
	localparam int conditionLsb = 0;

	localparam logic [groupWidth-1:0] groupSystem = 2'd0;
	localparam logic [groupWidth-1:0] groupLoadStore = 2'd1;
	localparam logic [groupWidth-1:0] groupJump = 2'd2;
	localparam logic [groupWidth-1:0] groupArithmeticLogic = 2'd3;

	localparam logic [3:0] aluOpMov = 4'd0;
	localparam logic [3:0] aluOpAdd = 4'd1;
	localparam logic [3:0] aluOpSub = 4'd2;
	localparam logic [3:0] aluOpAnd = 4'd3;
	localparam logic [3:0] aluOpOr = 4'd4;
	localparam logic [3:0] aluOpXor = 4'd5;
	localparam logic [3:0] aluOpShl = 4'd6;
	localparam logic [3:0] aluOpShr = 4'd7;

	localparam logic [2:0] aluASrcRegA = 3'd0;
	localparam logic [2:0] aluASrcPc = 3'd1;
	localparam logic [2:0] aluASrcZero = 3'd2;

	localparam logic [2:0] aluBSrcRegB = 3'd0;
	localparam logic [2:0] aluBSrcImm = 3'd1;
	localparam logic [2:0] aluBSrcTwo = 3'd2;

	localparam logic [2:0] addrBusPcA = 3'd0;
	localparam logic [2:0] addrBusAluR = 3'd1;
	localparam logic [2:0] addrBusRegB = 3'd2;
	localparam logic [2:0] addrBusDebug = 3'd3;

	localparam logic [1:0] busSeqNone = 2'd0;
	localparam logic [1:0] busSeqRead = 2'd1;
	localparam logic [1:0] busSeqWrite = 2'd2;

	localparam logic byteWord = 1'b0;
	localparam logic byteByte = 1'b1;

	localparam logic [1:0] ccRegKeep = 2'd0;
	localparam logic [1:0] ccRegSave = 2'd1;
	localparam logic [1:0] ccRegRestore = 2'd2;

	localparam logic [1:0] dataBusRegADout = 2'd0;
	localparam logic [1:0] dataBusAluR = 2'd1;

	localparam logic [1:0] pcBasePcA = 2'd0;
	localparam logic [1:0] pcBaseRegB = 2'd1;

	localparam logic [2:0] pcNextSeq = 3'd0;
	localparam logic [2:0] pcNextVector = 3'd1;
	localparam logic [2:0] pcNextBranch = 3'd2;
	localparam logic [2:0] pcNextHold = 3'd3;

	localparam logic [1:0] pcOffset2 = 2'd0;
	localparam logic [1:0] pcOffset4 = 2'd1;
	localparam logic [1:0] pcOffsetImm = 2'd2;

	localparam logic [3:0] regSeqNone = 4'd0;
	localparam logic [3:0] regSeqWriteA = 4'd1;
	localparam logic [3:0] regSeqReadAB = 4'd2;
	localparam logic [3:0] regSeqDebugWrite = 4'd3;

	localparam logic [1:0] regAAddrArgA = 2'd0;
	localparam logic [1:0] regAAddrLink = 2'd1;

	localparam logic [1:0] regADinDin = 2'd0;
	localparam logic [1:0] regADinAluR = 2'd1;
	localparam logic [1:0] regADinPc = 2'd2;

	localparam logic [2:0] regBAddrArgB = 3'd0;
	localparam logic [2:0] regBAddrSp = 3'd1;

endpackage

`default_nettype wire

/* hw/instructionLatch.sv */
`timescale 1ns/10ps
`default_nettype none

module instructionLatch (
	input  logic                                     CLK,
	input  logic                                     reset,
	input  logic                                     instrLoad,
	input  logic [cpuControlPkg::instrWidth-1:0]     instrWord,
	output logic [cpuControlPkg::groupWidth-1:0]     group,
	output logic [cpuControlPkg::opcodeWidth-1:0]    opcode,
	output logic [cpuControlPkg::argAWidth-1:0]      argA,
	output logic [cpuControlPkg::argBWidth-1:0]      argB,
	output logic [cpuControlPkg::conditionWidth-1:0] condition
);

	logic [cpuControlPkg::instrWidth-1:0] instrReg;

	// Zero decodes as a system no-op.
	always_ff @(posedge CLK) begin
		if (reset)
			instrReg <= '0;
		else if (instrLoad)
			instrReg <= instrWord;
	end

	assign group = instrReg[cpuControlPkg::groupLsb +: cpuControlPkg::groupWidth];
	assign opcode = instrReg[cpuControlPkg::opcodeLsb +: cpuControlPkg::opcodeWidth];
	assign argA = instrReg[cpuControlPkg::argALsb +: cpuControlPkg::argAWidth];
	assign argB = instrReg[cpuControlPkg::argBLsb +: cpuControlPkg::argBWidth];
	assign condition = instrReg[cpuControlPkg::conditionLsb +: cpuControlPkg::conditionWidth];

endmodule

`default_nettype wire

/* hw/aluGroupDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module aluGroupDecoder (
	input  logic [cpuControlPkg::opcodeWidth-1:0] opcode,
	output logic [3:0]                            aluOp,
	output logic [2:0]                            aluASrc,
	output logic [2:0]                            aluBSrc,
	output logic                                  cclLoad,
	output logic [1:0]                            regAAddr,
	output logic [2:0]                            regBAddr,
	output logic [3:0]                            regSeq
);

	logic isCompare;

	// Upper half repeats the lower ops with an immediate; 14 and 15 are compares.
	always_comb begin
		case (opcode)
			4'd0, 4'd8:         aluOp = cpuControlPkg::aluOpMov;
			4'd1, 4'd9:         aluOp = cpuControlPkg::aluOpAdd;
			4'd2, 4'd10, 4'd14: aluOp = cpuControlPkg::aluOpSub; // Cmpi subtracts.
			4'd3, 4'd11, 4'd15: aluOp = cpuControlPkg::aluOpAnd; // Tsti masks.
			4'd4, 4'd12:        aluOp = cpuControlPkg::aluOpOr;
			4'd5, 4'd13:        aluOp = cpuControlPkg::aluOpXor;
			4'd6:               aluOp = cpuControlPkg::aluOpShl;
			default:            aluOp = cpuControlPkg::aluOpShr;
		endcase
	end

	assign isCompare = (opcode == 4'd14) || (opcode == 4'd15);

	assign aluASrc = cpuControlPkg::aluASrcRegA;
	assign aluBSrc = opcode[3] ? cpuControlPkg::aluBSrcImm : cpuControlPkg::aluBSrcRegB;
	assign cclLoad = (opcode[2:0] != 3'd0); // Moves leave the flags alone.
	assign regAAddr = cpuControlPkg::regAAddrArgA;
	assign regBAddr = cpuControlPkg::regBAddrArgB;

	// Compares read both operands but write nothing back.
	assign regSeq = isCompare ? cpuControlPkg::regSeqReadAB : cpuControlPkg::regSeqWriteA;

endmodule

`default_nettype wire

/* hw/loadStoreGroupDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module loadStoreGroupDecoder (
	input  logic [cpuControlPkg::opcodeWidth-1:0] opcode,
	output logic [2:0]                            addrBus,
	output logic [3:0]                            aluOp,
	output logic [2:0]                            aluASrc,
	output logic [2:0]                            aluBSrc,
	output logic [1:0]                            busSeq,
	output logic                                  byteSel,
	output logic [1:0]                            dataBus,
	output logic [1:0]                            pcOffset,
	output logic [3:0]                            regSeq,
	output logic [1:0]                            regAAddr,
	output logic [1:0]                            regADin,
	output logic [2:0]                            regBAddr
);

	logic isStore;
	logic baseImm;

	assign isStore = opcode[0];
	assign baseImm = opcode[2]; // Base plus immediate, else register indirect.

	assign byteSel = opcode[1] ? cpuControlPkg::byteByte : cpuControlPkg::byteWord;

	// Base plus immediate forms PC plus the trailing immediate word in the ALU.
	assign addrBus = baseImm ? cpuControlPkg::addrBusAluR : cpuControlPkg::addrBusRegB;
	assign aluOp = baseImm ? cpuControlPkg::aluOpAdd : cpuControlPkg::aluOpMov;
	assign aluASrc = baseImm ? cpuControlPkg::aluASrcPc : cpuControlPkg::aluASrcZero;
	assign aluBSrc = baseImm ? cpuControlPkg::aluBSrcImm : cpuControlPkg::aluBSrcRegB;
	assign pcOffset = baseImm ? cpuControlPkg::pcOffset4 : cpuControlPkg::pcOffset2;

	assign busSeq = isStore ? cpuControlPkg::busSeqWrite : cpuControlPkg::busSeqRead;
	assign dataBus = cpuControlPkg::dataBusRegADout; // Store data from register A.
	assign regSeq = isStore ? cpuControlPkg::regSeqReadAB : cpuControlPkg::regSeqWriteA;
	assign regAAddr = cpuControlPkg::regAAddrArgA;
	assign regADin = cpuControlPkg::regADinDin; // Loads take bus data.
	assign regBAddr = cpuControlPkg::regBAddrArgB;

endmodule

`default_nettype wire

/* hw/jumpGroupDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module jumpGroupDecoder (
	input  logic [cpuControlPkg::opcodeWidth-1:0]    opcode,
	input  logic [cpuControlPkg::conditionWidth-1:0] condition,
	input  logic [cpuControlPkg::flagsWidth-1:0]     flags,
	output logic [2:0]                               addrBus,
	output logic [2:0]                               aluBSrc,
	output logic [1:0]                               busSeq,
	output logic [1:0]                               pcBase,
	output logic [1:0]                               pcOffset,
	output logic [3:0]                               regSeq,
	output logic [1:0]                               regADin,
	output logic [1:0]                               regAAddr,
	output logic [2:0]                               regBAddr
);

	logic taken;
	logic isCall;
	logic isReturn;

	// Condition is a mask over always, negative, carry and zero.
	assign taken = |(condition & {1'b1, flags});
	assign isCall = (opcode[1:0] == 2'd1);
	assign isReturn = (opcode[1:0] == 2'd2);

	// Return pops the target through the stack pointer.
	assign addrBus = isReturn ? cpuControlPkg::addrBusRegB : cpuControlPkg::addrBusPcA;
	assign busSeq = isReturn ? cpuControlPkg::busSeqRead : cpuControlPkg::busSeqNone;
	assign pcBase = isReturn ? cpuControlPkg::pcBaseRegB : cpuControlPkg::pcBasePcA;
	assign regBAddr = isReturn ? cpuControlPkg::regBAddrSp : cpuControlPkg::regBAddrArgB;
	assign aluBSrc = isReturn ? cpuControlPkg::aluBSrcTwo : cpuControlPkg::aluBSrcImm;

	assign pcOffset = (taken && !isReturn) ? cpuControlPkg::pcOffsetImm : cpuControlPkg::pcOffset2;

	// A taken call saves the return address in the link register.
	assign regAAddr = isCall ? cpuControlPkg::regAAddrLink : cpuControlPkg::regAAddrArgA;
	assign regADin = cpuControlPkg::regADinPc;
	assign regSeq = isReturn ? cpuControlPkg::regSeqReadAB :
		(isCall && taken) ? cpuControlPkg::regSeqWriteA : cpuControlPkg::regSeqNone;

endmodule

`default_nettype wire

/* hw/interruptControl.sv */
`timescale 1ns/10ps
`default_nettype none

module interruptControl (
	input  logic       CLK,
	input  logic       reset,
	input  logic       instrLoad,
	input  logic       irq,
	input  logic       intEnable,
	output logic [1:0] ccRegSel,
	output logic [2:0] pcNextSel
);

	logic pending;

	// Sampled at the instruction boundary, so it belongs to the new word.
	always_ff @(posedge CLK) begin
		if (reset)
			pending <= 1'b0;
		else if (instrLoad)
			pending <= irq & intEnable;
	end

	assign pcNextSel = pending ? cpuControlPkg::pcNextVector : cpuControlPkg::pcNextSeq;
	assign ccRegSel = pending ? cpuControlPkg::ccRegSave : cpuControlPkg::ccRegKeep;

endmodule

`default_nettype wire

/* hw/debugStepper.sv */
`timescale 1ns/10ps
`default_nettype none

module debugStepper (
	input  logic                                CLK,
	input  logic                                reset,
	input  logic                                instrLoad,
	input  logic                                debugMode,
	input  logic                                debugStep,
	output logic                                stepActive,
	input  logic [cpuControlPkg::argBWidth-1:0] debugArgB,
	output logic [1:0]                          debugBusSeq,
	output logic [1:0]                          debugCcReg,
	output logic [2:0]                          debugPcNext,
	output logic [3:0]                          debugRegSeq
);

	logic [1:0] stepSync;
	logic       stepRequest;
	logic       stepArmed;
	logic       memAccess;

	assign stepRequest = stepSync[1] & debugMode;

	always_ff @(posedge CLK) begin
		if (reset) begin
			stepSync <= 2'b00;
			stepArmed <= 1'b0;
			stepActive <= 1'b0;
		end else begin
			stepSync <= {stepSync[0], debugStep}; // Two-flop synchronizer.
			if (instrLoad) begin
				// One instruction interval per armed request.
				stepActive <= stepArmed;
				stepArmed <= stepRequest;
			end else if (stepRequest) begin
				stepArmed <= 1'b1;
			end
		end
	end

	// Top argB bit points the debugger at memory instead of the register file.
	assign memAccess = debugArgB[cpuControlPkg::argBWidth-1];

	// While armed, commit the debugger's register, flag and PC edits before the step.
	assign debugBusSeq = (memAccess && !stepArmed) ? cpuControlPkg::busSeqRead :
		cpuControlPkg::busSeqNone;
	assign debugCcReg = stepArmed ? cpuControlPkg::ccRegRestore : cpuControlPkg::ccRegKeep;
	assign debugPcNext = stepArmed ? cpuControlPkg::pcNextBranch : cpuControlPkg::pcNextHold;
	assign debugRegSeq = stepArmed ? cpuControlPkg::regSeqDebugWrite :
		memAccess ? cpuControlPkg::regSeqNone : cpuControlPkg::regSeqReadAB;

endmodule

`default_nettype wire

/* hw/opxMultiplexer.sv */
`timescale 1ns/10ps
`default_nettype none

module opxMultiplexer (
	input  logic [cpuControlPkg::groupWidth-1:0] group,
	input  logic [cpuControlPkg::argBWidth-1:0]  instrArgB,
	input  logic                                 debugMode,
	input  logic                                 stepActive,

	// Arithmetic-logic set.
	input  logic [3:0] aluAluOp, aluRegSeq,
	input  logic [2:0] aluAluASrc, aluAluBSrc, aluRegBAddr,
	input  logic [1:0] aluRegAAddr,
	input  logic       aluCclLoad,

	// Load-store set.
	input  logic [3:0] lsAluOp, lsRegSeq,
	input  logic [2:0] lsAddrBus, lsAluASrc, lsAluBSrc, lsRegBAddr,
	input  logic [1:0] lsBusSeq, lsDataBus, lsPcOffset, lsRegAAddr, lsRegADin,
	input  logic       lsByteSel,

	// Jump set.
	input  logic [3:0] jmpRegSeq,
	input  logic [2:0] jmpAddrBus, jmpAluBSrc, jmpRegBAddr,
	input  logic [1:0] jmpBusSeq, jmpPcBase, jmpPcOffset, jmpRegADin, jmpRegAAddr,

	input  logic [1:0] intCcReg,
	input  logic [2:0] intPcNext,

	input  logic [cpuControlPkg::argBWidth-1:0] debugArgB,
	input  logic [1:0] debugBusSeq, debugCcReg,
	input  logic [2:0] debugPcNext,
	input  logic [3:0] debugRegSeq,

	output logic [2:0] addrBus,
	output logic [3:0] aluOp,
	output logic [2:0] aluASrc,
	output logic [2:0] aluBSrc,
	output logic [cpuControlPkg::argBWidth-1:0] argB,
	output logic [1:0] busSeq,
	output logic       byteSel,
	output logic       cclLoad,
	output logic [1:0] ccReg,
	output logic [1:0] dataBus,
	output logic [1:0] pcBase,
	output logic [2:0] pcNext,
	output logic [1:0] pcOffset,
	output logic [3:0] regSeq,
	output logic [1:0] regAAddr,
	output logic [1:0] regADin,
	output logic [2:0] regBAddr
);

	always_comb begin
		// No-op set, overridden below.
		addrBus = cpuControlPkg::addrBusPcA;
		aluOp = cpuControlPkg::aluOpMov;
		aluASrc = cpuControlPkg::aluASrcRegA;
		aluBSrc = cpuControlPkg::aluBSrcRegB;
		busSeq = cpuControlPkg::busSeqNone;
		byteSel = cpuControlPkg::byteWord;
		cclLoad = 1'b0;
		dataBus = cpuControlPkg::dataBusRegADout;
		pcBase = cpuControlPkg::pcBasePcA;
		pcOffset = cpuControlPkg::pcOffset2;
		regSeq = cpuControlPkg::regSeqNone;
		regAAddr = cpuControlPkg::regAAddrArgA;
		regADin = cpuControlPkg::regADinDin;
		regBAddr = cpuControlPkg::regBAddrArgB;
		argB = instrArgB;
		ccReg = intCcReg;
		pcNext = intPcNext;

		if (debugMode && !stepActive) begin
			// Halted.
			addrBus = cpuControlPkg::addrBusDebug;
			argB = debugArgB;
			busSeq = debugBusSeq;
			ccReg = debugCcReg;
			pcNext = debugPcNext;
			regSeq = debugRegSeq;
		end else begin
			case (group)
				cpuControlPkg::groupSystem: ; // Keeps the no-op set.
				cpuControlPkg::groupLoadStore: begin
					addrBus = lsAddrBus;
					aluOp = lsAluOp;
					aluASrc = lsAluASrc;
					aluBSrc = lsAluBSrc;
					busSeq = lsBusSeq;
					byteSel = lsByteSel;
					dataBus = lsDataBus;
					pcOffset = lsPcOffset;
					regSeq = lsRegSeq;
					regAAddr = lsRegAAddr;
					regADin = lsRegADin;
					regBAddr = lsRegBAddr;
				end
				cpuControlPkg::groupJump: begin
					addrBus = jmpAddrBus;
					aluBSrc = jmpAluBSrc;
					busSeq = jmpBusSeq;
					pcBase = jmpPcBase;
					pcOffset = jmpPcOffset;
					regSeq = jmpRegSeq;
					regAAddr = jmpRegAAddr;
					regADin = jmpRegADin;
					regBAddr = jmpRegBAddr;
				end
				default: begin
					aluOp = aluAluOp; // Arithmetic-logic.
					aluASrc = aluAluASrc;
					aluBSrc = aluAluBSrc;
					cclLoad = aluCclLoad;
					dataBus = cpuControlPkg::dataBusAluR;
					regSeq = aluRegSeq;
					regAAddr = aluRegAAddr;
					regADin = cpuControlPkg::regADinAluR;
					regBAddr = aluRegBAddr;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/controlUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnit (
	input  logic                                 CLK,
	input  logic                                 reset,
	input  logic                                 instrLoad,
	input  logic [cpuControlPkg::instrWidth-1:0] instrWord,
	input  logic [cpuControlPkg::flagsWidth-1:0] flags,
	input  logic                                 irq,
	input  logic                                 intEnable,
	input  logic                                 debugMode,
	input  logic                                 debugStep,
	input  logic [cpuControlPkg::argBWidth-1:0]  debugArgB,
	output logic [2:0]                           addrBus,
	output logic [3:0]                           aluOp,
	output logic [2:0]                           aluASrc,
	output logic [2:0]                           aluBSrc,
	output logic [cpuControlPkg::argBWidth-1:0]  argB,
	output logic [1:0]                           busSeq,
	output logic                                 byteSel,
	output logic                                 cclLoad,
	output logic [1:0]                           ccReg,
	output logic [1:0]                           dataBus,
	output logic [1:0]                           pcBase,
	output logic [2:0]                           pcNext,
	output logic [1:0]                           pcOffset,
	output logic [3:0]                           regSeq,
	output logic [1:0]                           regAAddr,
	output logic [1:0]                           regADin,
	output logic [2:0]                           regBAddr
);

	logic [cpuControlPkg::groupWidth-1:0]     group;
	logic [cpuControlPkg::opcodeWidth-1:0]    opcode;
	logic [cpuControlPkg::argBWidth-1:0]      instrArgB;
	logic [cpuControlPkg::conditionWidth-1:0] condition;

	logic [3:0] aluAluOp, aluRegSeq, lsAluOp, lsRegSeq, jmpRegSeq, debugRegSeq;
	logic [2:0] aluAluASrc, aluAluBSrc, aluRegBAddr, lsAddrBus, lsAluASrc, lsAluBSrc;
	logic [2:0] lsRegBAddr, jmpAddrBus, jmpAluBSrc, jmpRegBAddr, intPcNext, debugPcNext;
	logic [1:0] aluRegAAddr, lsBusSeq, lsDataBus, lsPcOffset, lsRegAAddr, lsRegADin;
	logic [1:0] jmpBusSeq, jmpPcBase, jmpPcOffset, jmpRegADin, jmpRegAAddr;
	logic [1:0] intCcReg, debugBusSeq, debugCcReg;
	logic       aluCclLoad, lsByteSel, stepActive;

	// ArgA is the register file's own index and leaves no mark on the controls.
	instructionLatch instructionLatch_inst (
		.CLK, .reset, .instrLoad, .instrWord,
		.group, .opcode, .argA(), .argB(instrArgB), .condition
	);

	aluGroupDecoder aluGroupDecoder_inst (
		.opcode, .aluOp(aluAluOp), .aluASrc(aluAluASrc), .aluBSrc(aluAluBSrc),
		.cclLoad(aluCclLoad), .regAAddr(aluRegAAddr), .regBAddr(aluRegBAddr),
		.regSeq(aluRegSeq)
	);

	loadStoreGroupDecoder loadStoreGroupDecoder_inst (
		.opcode, .addrBus(lsAddrBus), .aluOp(lsAluOp), .aluASrc(lsAluASrc),
		.aluBSrc(lsAluBSrc), .busSeq(lsBusSeq), .byteSel(lsByteSel), .dataBus(lsDataBus),
		.pcOffset(lsPcOffset), .regSeq(lsRegSeq), .regAAddr(lsRegAAddr),
		.regADin(lsRegADin), .regBAddr(lsRegBAddr)
	);

	jumpGroupDecoder jumpGroupDecoder_inst (
		.opcode, .condition, .flags, .addrBus(jmpAddrBus), .aluBSrc(jmpAluBSrc),
		.busSeq(jmpBusSeq), .pcBase(jmpPcBase), .pcOffset(jmpPcOffset),
		.regSeq(jmpRegSeq), .regADin(jmpRegADin), .regAAddr(jmpRegAAddr),
		.regBAddr(jmpRegBAddr)
	);

	interruptControl interruptControl_inst (
		.CLK, .reset, .instrLoad, .irq, .intEnable,
		.ccRegSel(intCcReg), .pcNextSel(intPcNext)
	);

	debugStepper debugStepper_inst (
		.CLK, .reset, .instrLoad, .debugMode, .debugStep, .stepActive, .debugArgB,
		.debugBusSeq, .debugCcReg, .debugPcNext, .debugRegSeq
	);

	// Every port name matches a local wire or a top-level port.
	opxMultiplexer opxMultiplexer_inst (.*);

endmodule

`default_nettype wire

/* testbench/controlUnit_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnitProperties (
	input logic                                 CLK,
	input logic                                 reset,
	input logic                                 instrLoad,
	input logic                                 irq,
	input logic                                 intEnable,
	input logic                                 debugMode,
	input logic                                 stepActive,
	input logic [cpuControlPkg::groupWidth-1:0] group,
	input logic [cpuControlPkg::argBWidth-1:0]  instrArgB,
	input logic [cpuControlPkg::argBWidth-1:0]  debugArgB,
	input logic [cpuControlPkg::argBWidth-1:0]  argB,
	input logic [2:0]                           addrBus,
	input logic [1:0]                           busSeq,
	input logic [3:0]                           regSeq,
	input logic                                 cclLoad,
	input logic [1:0]                           ccReg,
	input logic [2:0]                           pcNext,
	input logic [1:0]                           intCcReg,
	input logic [2:0]                           intPcNext,
	input logic [1:0]                           debugBusSeq,
	input logic [3:0]                           debugRegSeq
);

	logic halted;
	int failures = 0;

	assign halted = debugMode && !stepActive;

	// Halted CPU shows the debugger's set.
	haltedUsesDebugSet: assert property (@(posedge CLK) disable iff (reset)
		halted |-> addrBus == cpuControlPkg::addrBusDebug && argB == debugArgB
			&& busSeq == debugBusSeq && regSeq == debugRegSeq)
	else begin
		failures = failures + 1;
		$error("halted CPU does not show the debug set");
	end

	runningUsesInterruptSelects: assert property (@(posedge CLK) disable iff (reset)
		!halted |-> ccReg == intCcReg && pcNext == intPcNext && argB == instrArgB)
	else begin
		failures = failures + 1;
		$error("running CPU ignores the interrupt selects or the latched argB");
	end

	systemGroupIsNoOp: assert property (@(posedge CLK) disable iff (reset)
		!halted && group == cpuControlPkg::groupSystem |->
			busSeq == cpuControlPkg::busSeqNone && regSeq == cpuControlPkg::regSeqNone
			&& !cclLoad)
	else begin
		failures = failures + 1;
		$error("system group does not give the no-op set");
	end

	// Accepted interrupt applies to the new word.
	interruptVectors: assert property (@(posedge CLK) disable iff (reset)
		instrLoad && irq && intEnable |=> halted
			|| (pcNext == cpuControlPkg::pcNextVector && ccReg == cpuControlPkg::ccRegSave))
	else begin
		failures = failures + 1;
		$error("accepted interrupt did not select the vector");
	end

	maskedInterruptKeepsSequence: assert property (@(posedge CLK) disable iff (reset)
		instrLoad && !(irq && intEnable) |=> halted
			|| (pcNext == cpuControlPkg::pcNextSeq && ccReg == cpuControlPkg::ccRegKeep))
	else begin
		failures = failures + 1;
		$error("masked interrupt changed the next-PC or CC register source");
	end

	stepLastsOneInstruction: assert property (@(posedge CLK) disable iff (reset)
		stepActive && !instrLoad |=> stepActive)
	else begin
		failures = failures + 1;
		$error("step qualifier dropped before the next instruction boundary");
	end

	resetClearsControls: assert property (@(posedge CLK)
		reset && !debugMode |=> debugMode || (busSeq == cpuControlPkg::busSeqNone
			&& regSeq == cpuControlPkg::regSeqNone && pcNext == cpuControlPkg::pcNextSeq))
	else begin
		failures = failures + 1;
		$error("controls are not idle after reset");
	end

endmodule

bind controlUnit controlUnitProperties controlUnitProperties_inst (.*);

`default_nettype wire

/* testbench/controlUnitTb.sv */
`timescale 1ns/10ps
`default_nettype none

module controlUnitTb;

	localparam int clockPeriod = 10;
	localparam int wordsPerGroup = 16;
	// One cycle per word, plus reset, interrupt and the debug step.
	localparam int testCycles = 11 + 4 * wordsPerGroup + 32 + 2 + 8 + 1;
	localparam int marginNs = 200;

	logic                                 CLK;
	logic                                 reset;
	logic                                 instrLoad;
	logic [cpuControlPkg::instrWidth-1:0] instrWord;
	logic [cpuControlPkg::flagsWidth-1:0] flags;
	logic                                 irq;
	logic                                 intEnable;
	logic                                 debugMode;
	logic                                 debugStep;
	logic [cpuControlPkg::argBWidth-1:0]  debugArgB;
	logic [2:0]                           addrBus;
	logic [3:0]                           aluOp;
	logic [2:0]                           aluASrc;
	logic [2:0]                           aluBSrc;
	logic [cpuControlPkg::argBWidth-1:0]  argB;
	logic [1:0]                           busSeq;
	logic                                 byteSel;
	logic                                 cclLoad;
	logic [1:0]                           ccReg;
	logic [1:0]                           dataBus;
	logic [1:0]                           pcBase;
	logic [2:0]                           pcNext;
	logic [1:0]                           pcOffset;
	logic [3:0]                           regSeq;
	logic [1:0]                           regAAddr;
	logic [1:0]                           regADin;
	logic [2:0]                           regBAddr;

	int seed = 71;
	int checks = 0;
	int errors = 0;
	int testChecks;
	int testErrors;

	controlUnit controlUnit_inst (.*);

	initial begin
		CLK = 1'b0;
		forever #(clockPeriod / 2) CLK = ~CLK;
	end

	task automatic checkCode(input string what, input int got, input int expected);
		checks++;
		if (got != expected) begin
			errors++;
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
		end
	endtask

	task automatic startTest();
		testChecks = checks;
		testErrors = errors;
	endtask

	task automatic endTest(input string name);
		$display("Test %s: %0d checks, %0d errors", name, checks - testChecks,
			errors - testErrors);
	endtask

	function automatic logic [15:0] randomWord(input logic [1:0] grp);
		logic [31:0] r;
		r = $random(seed);
		return {grp, r[13:0]};
	endfunction

	// Called on a falling edge; returns on the next one with the controls valid.
	task automatic loadWord(input logic [15:0] word);
		instrWord = word;
		instrLoad = 1'b1;
		@(negedge CLK);
		instrLoad = 1'b0;
	endtask

	// Mask over always, negative, carry and zero.
	function automatic logic jumpTaken(input logic [3:0] cond, input logic [2:0] f);
		return cond[3] || (cond[2] && f[2]) || (cond[1] && f[1]) || (cond[0] && f[0]);
	endfunction

	task automatic checkAluSet(input logic [3:0] opc);
		checkCode("aluASrc", int'(aluASrc), int'(cpuControlPkg::aluASrcRegA));
		checkCode("aluBSrc", int'(aluBSrc), opc >= 4'd8 ? int'(cpuControlPkg::aluBSrcImm) :
			int'(cpuControlPkg::aluBSrcRegB));
		checkCode("cclLoad", int'(cclLoad), int'(opc != 4'd0 && opc != 4'd8));
		checkCode("regSeq", int'(regSeq), opc >= 4'd14 ? int'(cpuControlPkg::regSeqReadAB) :
			int'(cpuControlPkg::regSeqWriteA));
		checkCode("regAAddr", int'(regAAddr), int'(cpuControlPkg::regAAddrArgA));
		checkCode("regBAddr", int'(regBAddr), int'(cpuControlPkg::regBAddrArgB));
	endtask

	task automatic groupTest(input logic [1:0] grp, input string name);
		logic [15:0] word;
		logic [3:0] opc;
		logic [31:0] r;
		startTest();
		for (int i = 0; i < wordsPerGroup; i++) begin
			r = $random(seed);
			flags = r[2:0];
			word = randomWord(grp);
			opc = word[13:10];
			loadWord(word);
			checkCode("argB", int'(argB), int'(word[7:4]));
			checkCode("pcNext", int'(pcNext), int'(cpuControlPkg::pcNextSeq));
			checkCode("ccReg", int'(ccReg), int'(cpuControlPkg::ccRegKeep));
			case (grp)
				cpuControlPkg::groupSystem: begin
					checkCode("busSeq", int'(busSeq), int'(cpuControlPkg::busSeqNone));
					checkCode("regSeq", int'(regSeq), int'(cpuControlPkg::regSeqNone));
					checkCode("cclLoad", int'(cclLoad), 0);
				end
				cpuControlPkg::groupLoadStore: begin
					checkCode("busSeq", int'(busSeq), opc[0] ? int'(cpuControlPkg::busSeqWrite) :
						int'(cpuControlPkg::busSeqRead));
					checkCode("byteSel", int'(byteSel), int'(opc[1]));
					checkCode("addrBus", int'(addrBus), opc[2] ? int'(cpuControlPkg::addrBusAluR) :
						int'(cpuControlPkg::addrBusRegB));
					if (opc[2])
						checkCode("aluOp", int'(aluOp), int'(cpuControlPkg::aluOpAdd));
					if (opc[0])
						checkCode("dataBus", int'(dataBus), int'(cpuControlPkg::dataBusRegADout));
					else
						checkCode("regADin", int'(regADin), int'(cpuControlPkg::regADinDin));
				end
				cpuControlPkg::groupJump: begin
					checkCode("pcOffset", int'(pcOffset), (jumpTaken(word[3:0], flags)
						&& opc[1:0] != 2'd2) ? int'(cpuControlPkg::pcOffsetImm) :
						int'(cpuControlPkg::pcOffset2));
					checkCode("pcBase", int'(pcBase), opc[1:0] == 2'd2 ?
						int'(cpuControlPkg::pcBaseRegB) : int'(cpuControlPkg::pcBasePcA));
					checkCode("regAAddr", int'(regAAddr), opc[1:0] == 2'd1 ?
						int'(cpuControlPkg::regAAddrLink) : int'(cpuControlPkg::regAAddrArgA));
					checkCode("regBAddr", int'(regBAddr), opc[1:0] == 2'd2 ?
						int'(cpuControlPkg::regBAddrSp) : int'(cpuControlPkg::regBAddrArgB));
				end
				default: checkAluSet(opc);
			endcase
		end
		endTest(name);
	endtask

	// Every single condition bit against every flag pattern.
	task automatic jumpConditionTest();
		logic [3:0] cond;
		startTest();
		for (int c = 0; c < 4; c++) begin
			for (int f = 0; f < 8; f++) begin
				cond = 4'b0001 << c;
				flags = 3'(f);
				loadWord({cpuControlPkg::groupJump, 10'd0, cond});
				checkCode("pcOffset", int'(pcOffset), jumpTaken(cond, flags) ?
					int'(cpuControlPkg::pcOffsetImm) : int'(cpuControlPkg::pcOffset2));
			end
		end
		endTest("jump conditions");
	endtask

	task automatic interruptTest();
		startTest();
		irq = 1'b1;
		intEnable = 1'b1;
		loadWord(randomWord(cpuControlPkg::groupArithmeticLogic));
		checkCode("pcNext", int'(pcNext), int'(cpuControlPkg::pcNextVector));
		checkCode("ccReg", int'(ccReg), int'(cpuControlPkg::ccRegSave));
		intEnable = 1'b0; // Masked.
		loadWord(randomWord(cpuControlPkg::groupArithmeticLogic));
		checkCode("pcNext", int'(pcNext), int'(cpuControlPkg::pcNextSeq));
		checkCode("ccReg", int'(ccReg), int'(cpuControlPkg::ccRegKeep));
		irq = 1'b0;
		endTest("interrupt");
	endtask

	task automatic debugTest();
		logic [15:0] word;
		logic [31:0] r;
		startTest();
		r = $random(seed);
		debugArgB = r[3:0];
		debugMode = 1'b1;
		@(negedge CLK);
		checkCode("addrBus", int'(addrBus), int'(cpuControlPkg::addrBusDebug));
		checkCode("argB", int'(argB), int'(debugArgB));
		checkCode("pcNext", int'(pcNext), int'(cpuControlPkg::pcNextHold));
		debugStep = 1'b1;
		@(negedge CLK);
		debugStep = 1'b0;
		repeat (3) @(negedge CLK); // Two synchronizer cycles, then arming.
		word = randomWord(cpuControlPkg::groupArithmeticLogic);
		loadWord(word);
		checkCode("argB", int'(argB), int'(word[7:4]));
		checkAluSet(word[13:10]);
		@(negedge CLK);
		checkCode("argB", int'(argB), int'(word[7:4]));
		loadWord(randomWord(cpuControlPkg::groupArithmeticLogic));
		checkCode("addrBus", int'(addrBus), int'(cpuControlPkg::addrBusDebug));
		checkCode("argB", int'(argB), int'(debugArgB));
		debugMode = 1'b0;
		endTest("debug step");
	endtask

	initial begin
		int assertFails;
		reset = 1'b1;
		instrLoad = 1'b0;
		instrWord = '0;
		flags = '0;
		irq = 1'b0;
		intEnable = 1'b0;
		debugMode = 1'b0;
		debugStep = 1'b0;
		debugArgB = '0;
		repeat (10) @(negedge CLK);
		reset = 1'b0;
		@(negedge CLK);

		startTest();
		checkCode("busSeq", int'(busSeq), int'(cpuControlPkg::busSeqNone));
		checkCode("regSeq", int'(regSeq), int'(cpuControlPkg::regSeqNone));
		checkCode("pcNext", int'(pcNext), int'(cpuControlPkg::pcNextSeq));
		endTest("reset");

		groupTest(cpuControlPkg::groupSystem, "system group");
		groupTest(cpuControlPkg::groupLoadStore, "load-store group");
		groupTest(cpuControlPkg::groupJump, "jump group");
		groupTest(cpuControlPkg::groupArithmeticLogic, "arithmetic-logic group");
		jumpConditionTest();
		interruptTest();
		debugTest();

		@(negedge CLK);
		assertFails = controlUnit_inst.controlUnitProperties_inst.failures;
		$display("Totals: %0d checks, %0d mismatches, %0d assertion failures", checks,
			errors, assertFails);
		if (errors == 0 && assertFails == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		#(testCycles * clockPeriod + marginNs);
		$display("Timeout: the tests did not finish within %0d ns",
			testCycles * clockPeriod + marginNs);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
hw/cpuControlPkg.sv
hw/instructionLatch.sv
hw/aluGroupDecoder.sv
hw/loadStoreGroupDecoder.sv
hw/jumpGroupDecoder.sv
hw/interruptControl.sv
hw/debugStepper.sv
hw/opxMultiplexer.sv
hw/controlUnit.sv
testbench/controlUnit_properties.sv
testbench/controlUnitTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = controlUnitTb
FILELIST = sources.f

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; echo "$$out"; \
		echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
